/* src.f */
+incdir+include
verilog/net_pkg.sv
verilog/net_rr_arb.sv
verilog/net_input_unit.sv
verilog/net_output_ctrl.sv
verilog/net_router.sv
verification/net_router_tb.sv

/* Makefile */
# Verilator build and run of the router testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module net_router_tb -f src.f
	./obj_dir/Vnet_router_tb | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/net_router_tb.sv */
/*
 * testbench for the three port router
 * mixed, fairness and back-pressure traffic checked by assertions
 */

`timescale 1ns/100ps

`include "net_macros.svh"

module net_router_tb import net_pkg::*; ();

	localparam int num_ports = `NET_NUM_PORTS;
	// router position on the chain, terminal traffic carries dest 1
	localparam logic [node_bits-1:0] tb_id = 1;
	localparam int n_random = 40;
	localparam int n_fair = 12;
	localparam int n_bp = 6;
	// a message needs at most a few cycles while three inputs share one output
	localparam int stim_cycles = 3 * (n_random + n_fair + n_bp) + 2;
	localparam int mode_random = 0;
	localparam int mode_fair = 1;
	localparam int mode_east = 2;

	logic clk = 1'b0;
	logic reset;
	net_msg_t in_msg [num_ports];
	logic in_val [num_ports];
	logic in_rdy [num_ports];
	net_msg_t out_msg [num_ports];
	logic out_val [num_ports];
	logic out_rdy [num_ports];
	logic out_domain [num_ports];

	int seed = 39;
	int errors = 0;
	// expected messages, one FIFO per input and output pair at input * 3 + output
	net_msg_t exp_q [num_ports * num_ports][$];
	logic stall_on = 1'b0;
	logic [num_ports-1:0] hold_rdy = '0;
	logic fair_on = 1'b0;
	logic [num_ports-1:0] won_mask = '0;
	logic rst_seen = 1'b1;
	logic prev_val [num_ports];
	logic prev_dom [num_ports];

	net_router DUT (
		.clk           (clk),
		.reset         (reset),
		.router_id     (tb_id),
		.p0_in_msg     (in_msg[0]),
		.p0_in_val     (in_val[0]),
		.p0_in_rdy     (in_rdy[0]),
		.p0_out_msg    (out_msg[0]),
		.p0_out_val    (out_val[0]),
		.p0_out_rdy    (out_rdy[0]),
		.p0_out_domain (out_domain[0]),
		.p1_in_msg     (in_msg[1]),
		.p1_in_val     (in_val[1]),
		.p1_in_rdy     (in_rdy[1]),
		.p1_out_msg    (out_msg[1]),
		.p1_out_val    (out_val[1]),
		.p1_out_rdy    (out_rdy[1]),
		.p1_out_domain (out_domain[1]),
		.p2_in_msg     (in_msg[2]),
		.p2_in_val     (in_val[2]),
		.p2_in_rdy     (in_rdy[2]),
		.p2_out_msg    (out_msg[2]),
		.p2_out_val    (out_val[2]),
		.p2_out_rdy    (out_rdy[2]),
		.p2_out_domain (out_domain[2])
	);

	always #5 clk = ~clk;

	// ------------------------------
	// helpers
	// ------------------------------

	task automatic flag_error(input string what);
		$display("ERROR %0t: %s", $time, what);
		errors++;
	endtask

	// chain rule, own id to the terminal, larger ids east, smaller ids west
	function automatic int route_of(input logic [node_bits-1:0] dest);
		if (dest == tb_id)
			return 1;
		if (dest > tb_id)
			return 2;
		return 0;
	endfunction

	function automatic int count_pending();
		int total;
		total = 0;
		for (int k = 0; k < num_ports * num_ports; k++)
			total += exp_q[k].size();
		return total;
	endfunction

	// one sender, holds msg and val until the DUT takes the message
	task automatic send_burst(input int port, input int count, input int mode);
		net_msg_t m;
		logic [31:0] r;
		for (int n = 0; n < count; n++) begin
			r = $random(seed);
			m.src = node_bits'(port);
			m.payload = r[`NET_PAYLOAD_BITS-1:0];
			case (mode)
				mode_fair: begin
					m.dest = tb_id;
					m.domain = 1'b0;
				end
				mode_east: begin
					m.dest = node_bits'(3);
					m.domain = 1'b1;
				end
				default: begin
					m.dest = r[9:8];
					m.domain = r[10];
				end
			endcase
			in_msg[port] = m;
			in_val[port] = 1'b1;
			do
				@(negedge clk);
			while (!in_rdy[port]);
			@(posedge clk);
			#1;
			in_val[port] = 1'b0;
		end
	endtask

	task automatic wait_drained(input int limit);
		int waited;
		waited = 0;
		while (count_pending() != 0 && waited < limit) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (count_pending() != 0) begin
			$display("%0d sent messages never came out of the router", count_pending());
			errors++;
		end
	endtask

	// receiver ready, flags are taken at the edge and driven 1 ns later
	always @(posedge clk) begin : rdy_driver
		logic [num_ports-1:0] held;
		logic rand_on;
		held = hold_rdy;
		rand_on = stall_on;
		#1;
		for (int p = 0; p < num_ports; p++) begin
			if (held[p])
				out_rdy[p] = 1'b0;
			else if (rand_on)
				out_rdy[p] = ($random(seed) & 3) != 0;
			else
				out_rdy[p] = 1'b1;
		end
	end

	// ------------------------------
	// checks at the falling edge
	// ------------------------------

	// inputs change only just after a rising edge, so at the falling edge
	// every value equals what the next rising edge will see
	always @(negedge clk) begin : monitor
		net_msg_t exp;
		int k;
		int src;
		for (int p = 0; p < num_ports; p++) begin
			if (reset || rst_seen) begin
				assert (!out_val[p] && in_rdy[p])
					else flag_error($sformatf("port %0d not idle around reset", p));
			end
			// the first cycle after reset already carries input transfers
			if (!reset) begin
				if (in_val[p] && in_rdy[p])
					exp_q[p * num_ports + route_of(in_msg[p].dest)].push_back(in_msg[p]);
				assert (out_rdy[p] || !out_val[p])
					else flag_error($sformatf("output %0d moved a message while stalled", p));
				// the domain may only turn over after a cycle without a transfer
				assert (out_domain[p] == prev_dom[p] || !prev_val[p])
					else flag_error($sformatf("output %0d switched domain after a transfer", p));
				if (out_val[p] && out_rdy[p]) begin
					src = int'(out_msg[p].src);
					assert (route_of(out_msg[p].dest) == p)
						else flag_error($sformatf("dest %0d left on port %0d",
							out_msg[p].dest, p));
					assert (out_msg[p].domain == out_domain[p])
						else flag_error($sformatf("domain %0d message on domain %0d port %0d",
							out_msg[p].domain, out_domain[p], p));
					assert (src < num_ports)
						else flag_error($sformatf("bad source %0d on port %0d", src, p));
					if (src < num_ports) begin
						k = src * num_ports + p;
						assert (exp_q[k].size() != 0)
							else flag_error($sformatf("unexpected message %0d to %0d", src, p));
						if (exp_q[k].size() != 0) begin
							exp = exp_q[k].pop_front();
							assert (out_msg[p] == exp)
								else flag_error($sformatf("port %0d got %h, expected %h",
									p, out_msg[p], exp));
						end
					end
					// a repeat winner is only allowed once all three have won
					if (fair_on && p == 1 && src < num_ports) begin
						if (won_mask[src]) begin
							assert (&won_mask)
								else flag_error($sformatf("input %0d won twice early", src));
							won_mask = '0;
						end
						won_mask[src] = 1'b1;
					end
				end
			end
			prev_dom[p] = out_domain[p];
			prev_val[p] = out_val[p];
		end
		rst_seen = reset;
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	initial begin
		reset = 1'b1;
		for (int p = 0; p < num_ports; p++) begin
			in_msg[p] = '0;
			in_val[p] = 1'b0;
			out_rdy[p] = 1'b1;
		end
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// mixed destinations and domains with random receiver stalls
		stall_on = 1'b1;
		fork
			send_burst(0, n_random, mode_random);
			send_burst(1, n_random, mode_random);
			send_burst(2, n_random, mode_random);
		join
		stall_on = 1'b0;
		wait_drained(200);

		// all three inputs competing for the terminal port in domain 0
		won_mask = '0;
		fair_on = 1'b1;
		fork
			send_burst(0, n_fair, mode_fair);
			send_burst(1, n_fair, mode_fair);
			send_burst(2, n_fair, mode_fair);
		join
		wait_drained(200);
		fair_on = 1'b0;

		// east receiver held off until every input queue has filled
		hold_rdy[2] = 1'b1;
		fork
			send_burst(0, n_bp, mode_east);
			send_burst(1, n_bp, mode_east);
			send_burst(2, n_bp, mode_east);
			begin
				repeat (6) @(negedge clk);
				for (int p = 0; p < num_ports; p++)
					assert (!in_rdy[p])
						else flag_error($sformatf("input %0d still ready behind stall", p));
				@(posedge clk);
				#1;
				hold_rdy[2] = 1'b0;
			end
		join
		wait_drained(200);

		$display("run complete, %0d errors", errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog sized from the stimulus length
	initial begin
		#(20 * stim_cycles * 10);
		$display("watchdog expired with %0d messages still in flight", count_pending());
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* verilog/net_router.sv */
/*
 * three port router top, west, terminal and east
 * input units and output controls joined by request and grant wiring
 */

`timescale 1ns/100ps

`include "net_macros.svh"

module net_router import net_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [node_bits-1:0] router_id,

	input  net_msg_t             p0_in_msg,
	input  logic                 p0_in_val,
	output logic                 p0_in_rdy,
	output net_msg_t             p0_out_msg,
	output logic                 p0_out_val,
	input  logic                 p0_out_rdy,
	output logic                 p0_out_domain,

	input  net_msg_t             p1_in_msg,
	input  logic                 p1_in_val,
	output logic                 p1_in_rdy,
	output net_msg_t             p1_out_msg,
	output logic                 p1_out_val,
	input  logic                 p1_out_rdy,
	output logic                 p1_out_domain,

	input  net_msg_t             p2_in_msg,
	input  logic                 p2_in_val,
	output logic                 p2_in_rdy,
	output net_msg_t             p2_out_msg,
	output logic                 p2_out_val,
	input  logic                 p2_out_rdy,
	output logic                 p2_out_domain
);

	localparam int num_ports = `NET_NUM_PORTS;

	// ------------------------------
	// port bundles as arrays
	// ------------------------------

	net_msg_t in_msg [num_ports];
	logic [num_ports-1:0] in_val;
	logic [num_ports-1:0] in_rdy;
	net_msg_t out_msg [num_ports];
	logic [num_ports-1:0] out_val;
	logic [num_ports-1:0] out_rdy;
	logic [num_ports-1:0] out_domain;

	assign in_msg[0] = p0_in_msg;
	assign in_msg[1] = p1_in_msg;
	assign in_msg[2] = p2_in_msg;
	assign in_val = {p2_in_val, p1_in_val, p0_in_val};
	assign {p2_in_rdy, p1_in_rdy, p0_in_rdy} = in_rdy;

	assign p0_out_msg = out_msg[0];
	assign p1_out_msg = out_msg[1];
	assign p2_out_msg = out_msg[2];
	assign {p2_out_val, p1_out_val, p0_out_val} = out_val;
	assign out_rdy = {p2_out_rdy, p1_out_rdy, p0_out_rdy};
	assign {p2_out_domain, p1_out_domain, p0_out_domain} = out_domain;

	// ------------------------------
	// request and grant wiring
	// ------------------------------

	// in_ vectors are indexed by output, out_ vectors by input
	logic [num_ports-1:0] in_reqs [num_ports];
	logic [num_ports-1:0] in_grants [num_ports];
	logic [num_ports-1:0] out_reqs [num_ports];
	logic [num_ports-1:0] out_grants [num_ports];
	// every output sees every head, its own mask decides which it takes
	net_msg_t head_msgs [num_ports];

	// transpose, request bit j of input i is request bit i of output j
	for (genvar i = 0; i < num_ports; i++) begin : g_xpose_in
		for (genvar j = 0; j < num_ports; j++) begin : g_xpose_out
			assign out_reqs[j][i] = in_reqs[i][j];
			assign in_grants[i][j] = out_grants[j][i];
		end
	end

	for (genvar i = 0; i < num_ports; i++) begin : g_in
		net_input_unit in_unit (
			.clk       (clk),
			.reset     (reset),
			.router_id (router_id),
			.in_msg    (in_msg[i]),
			.in_val    (in_val[i]),
			.in_rdy    (in_rdy[i]),
			.grants    (in_grants[i]),
			.reqs      (in_reqs[i]),
			.head_msg  (head_msgs[i])
		);
	end

	for (genvar j = 0; j < num_ports; j++) begin : g_out
		net_output_ctrl out_ctrl (
			.clk        (clk),
			.reset      (reset),
			.reqs       (out_reqs[j]),
			.req_msgs   (head_msgs),
			.grants     (out_grants[j]),
			.out_msg    (out_msg[j]),
			.out_val    (out_val[j]),
			.out_rdy    (out_rdy[j]),
			.out_domain (out_domain[j])
		);
	end

endmodule

/* verilog/net_output_ctrl.sv */
/*
 * output port control with a per output security domain
 * domain masked round robin arbitration and the crossbar column
 */

`timescale 1ns/100ps

`include "net_macros.svh"

module net_output_ctrl import net_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`NET_NUM_PORTS-1:0] reqs,
	input  net_msg_t                  req_msgs [`NET_NUM_PORTS],
	output logic [`NET_NUM_PORTS-1:0] grants,
	output net_msg_t                  out_msg,
	output logic                      out_val,
	input  logic                      out_rdy,
	output logic                      out_domain
);

	localparam int num_ports = `NET_NUM_PORTS;

	// ------------------------------
	// domain filtering
	// ------------------------------

	// requests split by whether the head message is in the domain
	// this output currently serves
	logic [num_ports-1:0] match;
	logic [num_ports-1:0] mismatch;
	logic [num_ports-1:0] arb_reqs;
	logic switch_domain;

	always_comb begin
		for (int i = 0; i < num_ports; i++) begin
			match[i] = reqs[i] && (req_msgs[i].domain == out_domain);
			mismatch[i] = reqs[i] && (req_msgs[i].domain != out_domain);
		end
	end

	// the arbiter never sees a request from the other domain, so
	// a foreign message can not be granted onto this link at all
	// with the receiver stalled nothing is offered either, which
	// keeps grant and transfer the same event
	assign arb_reqs = out_rdy ? match : '0;

	// ------------------------------
	// arbitration
	// ------------------------------

	net_rr_arb arbiter (
		.clk    (clk),
		.reset  (reset),
		.reqs   (arb_reqs),
		.grants (grants)
	);

	assign out_val = |grants;

	// ------------------------------
	// crossbar column
	// ------------------------------

	net_port_t xbar_sel;

	// grants are one hot, so the last set bit is the only set bit
	always_comb begin
		xbar_sel = port_west;
		for (int i = 0; i < num_ports; i++) begin
			if (grants[i])
				xbar_sel = net_port_t'(i);
		end
	end

	assign out_msg = req_msgs[xbar_sel];

	// ------------------------------
	// domain register
	// ------------------------------

	// flip only when nothing in the current domain is waiting and
	// something from the other domain is, the link is idle in that cycle
	// this flip does not look at out_rdy, a stalled link can still turn
	assign switch_domain = !(|match) && (|mismatch);

	always_ff @(posedge clk) begin
		if (reset)
			out_domain <= 1'b0;
		else if (switch_domain)
			out_domain <= !out_domain;
	end

	// every message on the link belongs to the domain the link advertises
	a_domain_match: assert property (@(posedge clk) disable iff (reset)
		out_val |-> out_msg.domain == out_domain);

	// the domain only turns over on a cycle with no transfer
	a_domain_idle_switch: assert property (@(posedge clk) disable iff (reset)
		out_domain != $past(out_domain) |-> !$past(out_val));

endmodule

/* verilog/net_input_unit.sv */
/*
 * input port of the router
 * two entry message queue and route lookup for the head
 */

`timescale 1ns/100ps

`include "net_macros.svh"

module net_input_unit import net_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [node_bits-1:0]      router_id,
	input  net_msg_t                  in_msg,
	input  logic                      in_val,
	output logic                      in_rdy,
	input  logic [`NET_NUM_PORTS-1:0] grants,
	output logic [`NET_NUM_PORTS-1:0] reqs,
	output net_msg_t                  head_msg
);

	localparam int depth = `NET_QUEUE_DEPTH;
	localparam int ptr_bits = $clog2(depth);
	localparam int cnt_bits = $clog2(depth + 1);

	// ------------------------------
	// message queue
	// ------------------------------

	net_msg_t entries [depth];
	logic [ptr_bits-1:0] head_ptr;
	logic [ptr_bits-1:0] tail_ptr;
	logic [cnt_bits-1:0] count;
	logic empty;
	logic full;
	logic push;
	logic pop;

	assign empty = (count == '0);
	assign full = (count == cnt_bits'(depth));

	// the sender may push whenever a slot is free, even if a pop is
	// happening in the same cycle on a full queue it must wait
	assign in_rdy = !full;
	assign push = in_val && in_rdy;

	// a grant from any output means the head leaves this cycle
	assign pop = |grants;

	// the slot at the tail takes the incoming message
	always_ff @(posedge clk) begin
		if (push)
			entries[tail_ptr] <= in_msg;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				tail_ptr <= (tail_ptr == ptr_bits'(depth - 1)) ? '0 : tail_ptr + 1'b1;
			if (pop)
				head_ptr <= (head_ptr == ptr_bits'(depth - 1)) ? '0 : head_ptr + 1'b1;
			// simultaneous push and pop leave the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign head_msg = entries[head_ptr];

	// ------------------------------
	// route computation
	// ------------------------------

	net_port_t route;

	// nodes sit on a line, so the comparison alone picks the direction
	always_comb begin
		if (head_msg.dest == router_id)
			route = port_term;
		else if (head_msg.dest > router_id)
			route = port_east;
		else
			route = port_west;
	end

	// one hot request toward the routed output, silent while empty
	always_comb begin
		reqs = '0;
		if (!empty)
			reqs[route] = 1'b1;
	end

	// the output controls only grant what was requested, so any grant
	// must find a message here, and never more than one output grants it
	a_grant_has_head: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty && $onehot(grants));

	// a message offered to a full queue stays on the port until room opens
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		in_val && full |=> in_val && $stable(in_msg));

endmodule

/* verilog/net_rr_arb.sv */
/*
 * round robin arbiter over the router ports
 */

`timescale 1ns/100ps

`include "net_macros.svh"

module net_rr_arb (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`NET_NUM_PORTS-1:0] reqs,
	output logic [`NET_NUM_PORTS-1:0] grants
);

	localparam int num_reqs = `NET_NUM_PORTS;
	localparam int ptr_bits = $clog2(num_reqs);

	// first position searched in the current cycle
	logic [ptr_bits-1:0] prio;
	// index of the winning requester, only meaningful when found is set
	logic [ptr_bits-1:0] winner;
	logic found;

	// walk the requesters starting at the priority pointer
	// the first one that is asking wins
	always_comb begin
		grants = '0;
		winner = prio;
		found = 1'b0;
		for (int k = 0; k < num_reqs; k++) begin
			if (!found && reqs[(int'(prio) + k) % num_reqs]) begin
				found = 1'b1;
				winner = ptr_bits'((int'(prio) + k) % num_reqs);
			end
		end
		if (found)
			grants[winner] = 1'b1;
	end

	// the pointer moves one past the winner, and holds when nobody asked
	// after reset port 0 is searched first
	always_ff @(posedge clk) begin
		if (reset)
			prio <= '0;
		else if (found)
			prio <= (winner == ptr_bits'(num_reqs - 1)) ? '0 : winner + 1'b1;
	end

	// at most one winner, and only ever one that was asking
	a_grant_legal: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grants) && ((grants & ~reqs) == '0));

endmodule

/* verilog/net_pkg.sv */
/*
 * shared types for the router
 * message struct and the port select enum
 */

`include "net_macros.svh"

package net_pkg;

	// width of a node id on the chain
	localparam int node_bits = $clog2(`NET_NUM_NODES);

	// ------------------------------
	// message format
	// ------------------------------

	// one message as it travels through the network
	// the fields are packed msb first in the order below
	typedef struct packed {
		// node the message is heading for
		logic [node_bits-1:0] dest;
		// node that injected the message
		logic [node_bits-1:0] src;
		// security domain, an output only forwards the domain it holds
		logic domain;
		// opaque data
		logic [`NET_PAYLOAD_BITS-1:0] payload;
	} net_msg_t;

	// ------------------------------
	// port names
	// ------------------------------

	// used both as a route result and as a crossbar select
	// the encoding matches the bit position in the request vectors
	typedef enum logic [1:0] {
		port_west = 2'd0,
		port_term = 2'd1,
		port_east = 2'd2
	} net_port_t;

endpackage

/* include/net_macros.svh */
/*
 * sizing macros for the secure mesh router
 * port count, node count, queue depth and payload width
 */

`ifndef NET_MACROS_SVH
`define NET_MACROS_SVH

// ------------------------------
// router geometry
// ------------------------------

// west, terminal and east
`define NET_NUM_PORTS 3

// nodes on the linear chain, ids are log2 of this wide
`define NET_NUM_NODES 4

// ------------------------------
// buffering and payload
// ------------------------------

// entries held by each input queue
`define NET_QUEUE_DEPTH 2

// data bits carried by one message
`define NET_PAYLOAD_BITS 8

`endif
